// File: hdl/ce_pkg.sv
`default_nettype none

package ce_pkg;

   // ----------------------------------------------------------------------
   // Widths with a meaning of their own
   // ----------------------------------------------------------------------
   typedef logic [31:0] addr_t;       // Host or device byte address
   typedef logic [63:0] data_t;       // One copied word
   typedef logic [15:0] len_t;        // Copy length in words
   typedef logic [7:0]  mmio_addr_t;  // MMIO register offset
   typedef logic [3:0]  credit_t;     // Credit or occupancy count

   // Copy control FSM
   typedef enum logic [1:0] {
      CE_IDLE,
      CE_RUN,
      CE_DONE
   } ctrl_state_t;

   // ----------------------------------------------------------------------
   // Sizing
   // ----------------------------------------------------------------------
   localparam int CE_REQ_CREDITS = 4;   // Host request credits after reset
   localparam int CE_CPL_DEPTH   = 8;   // Completion FIFO entries
   localparam int CE_CPL_AW      = $clog2(CE_CPL_DEPTH);

   typedef logic [CE_CPL_AW-1:0] cpl_ptr_t;

   localparam addr_t        CE_ADDR_STEP = 32'd8;  // Bytes per word
   localparam logic [15:0]  CE_FEAT_ID   = 16'h00CE;

   // ----------------------------------------------------------------------
   // Register map
   // ----------------------------------------------------------------------
   localparam mmio_addr_t CE_REG_ID     = 8'h00;
   localparam mmio_addr_t CE_REG_SRC    = 8'h08;
   localparam mmio_addr_t CE_REG_DST    = 8'h10;
   localparam mmio_addr_t CE_REG_LEN    = 8'h18;
   localparam mmio_addr_t CE_REG_CTRL   = 8'h20;  // Bit 0 rings the doorbell
   localparam mmio_addr_t CE_REG_STATUS = 8'h28;  // busy, done, err, count[31:16]

endpackage

`default_nettype wire

// File: hdl/ce_csr.sv
`timescale 1ns/100ps
`default_nettype none

module ce_csr (
   input  logic                 fim_clk,
   input  logic                 rst_n,

   input  logic                 mmio_wr_valid,
   input  logic                 mmio_rd_valid,
   input  ce_pkg::mmio_addr_t   mmio_addr,
   input  ce_pkg::data_t        mmio_wdata,
   output logic                 mmio_rd_ack,
   output ce_pkg::data_t        mmio_rdata,

   input  logic                 busy,
   input  logic                 done,
   input  logic                 err,
   input  ce_pkg::len_t         count,

   output ce_pkg::addr_t        src_addr,
   output ce_pkg::addr_t        dst_addr,
   output ce_pkg::len_t         len,
   output logic                 doorbell
);

   logic          db_write;
   ce_pkg::data_t rd_mux;

   assign db_write = mmio_wr_valid && (mmio_addr == ce_pkg::CE_REG_CTRL) && mmio_wdata[0];

   // ----------------------------------------------------------------------
   // Descriptor registers
   // ----------------------------------------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         src_addr <= '0;
         dst_addr <= '0;
         len      <= '0;
      end else if (mmio_wr_valid) begin
         case (mmio_addr)
            ce_pkg::CE_REG_SRC: src_addr <= mmio_wdata[31:0];
            ce_pkg::CE_REG_DST: dst_addr <= mmio_wdata[31:0];
            ce_pkg::CE_REG_LEN: len      <= mmio_wdata[15:0];
            default: ;
         endcase
      end
   end

   // One-cycle doorbell, dropped while a copy is running or just launched
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         doorbell <= 1'b0;
      end else begin
         doorbell <= db_write && !busy && !doorbell;
      end
   end

   // ----------------------------------------------------------------------
   // Read path
   // ----------------------------------------------------------------------
   always_comb begin
      rd_mux = '0;  // Unmapped offsets read zero
      case (mmio_addr)
         ce_pkg::CE_REG_ID:     rd_mux[15:0] = ce_pkg::CE_FEAT_ID;
         ce_pkg::CE_REG_SRC:    rd_mux[31:0] = src_addr;
         ce_pkg::CE_REG_DST:    rd_mux[31:0] = dst_addr;
         ce_pkg::CE_REG_LEN:    rd_mux[15:0] = len;
         ce_pkg::CE_REG_STATUS: begin
            rd_mux[31:16] = count;
            rd_mux[2:0]   = {err, done, busy};
         end
         default: ;
      endcase
   end

   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         mmio_rd_ack <= 1'b0;
      end else begin
         mmio_rd_ack <= mmio_rd_valid;
      end
   end

   always_ff @(posedge fim_clk) begin
      if (mmio_rd_valid) begin
         mmio_rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// File: hdl/ce_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ce_ctrl (
   input  logic           fim_clk,
   input  logic           rst_n,

   input  logic           doorbell,   // From the CSR block
   input  ce_pkg::len_t   len,
   input  logic           wr_beat,    // One per accepted device write

   output logic           start,
   output logic           busy,
   output logic           done,
   output logic           err,
   output ce_pkg::len_t   count
);

   ce_pkg::ctrl_state_t state;
   ce_pkg::len_t        count_next;

   assign count_next = count + ce_pkg::len_t'(1);

   // ----------------------------------------------------------------------
   // Copy FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ce_pkg::CE_IDLE;
         start <= 1'b0;
         err   <= 1'b0;
         count <= '0;
      end else begin
         start <= 1'b0;  // Pulse only
         case (state)
            ce_pkg::CE_IDLE,
            ce_pkg::CE_DONE: begin
               if (doorbell) begin
                  count <= '0;
                  if (len != '0) begin
                     state <= ce_pkg::CE_RUN;
                     start <= 1'b1;
                     err   <= 1'b0;
                  end else begin
                     // Nothing to copy, flag it and finish at once
                     state <= ce_pkg::CE_DONE;
                     err   <= 1'b1;
                  end
               end
            end

            ce_pkg::CE_RUN: begin
               if (wr_beat) begin
                  count <= count_next;
                  if (count_next == len) begin
                     state <= ce_pkg::CE_DONE;  // Last word landed
                  end
               end
            end

            default: begin
               state <= ce_pkg::CE_IDLE;
            end
         endcase
      end
   end

   // Status flags follow the state register directly
   assign busy = (state == ce_pkg::CE_RUN);
   assign done = (state == ce_pkg::CE_DONE);

endmodule

`default_nettype wire

// File: hdl/ce_rd_req_gen.sv
`timescale 1ns/100ps
`default_nettype none

module ce_rd_req_gen (
   input  logic              fim_clk,
   input  logic              rst_n,

   input  logic              start,
   input  ce_pkg::addr_t     src_addr,
   input  ce_pkg::len_t      len,

   input  logic              req_credit_return,
   input  logic              cpl_valid,
   input  ce_pkg::credit_t   buf_count,

   output logic              req_valid,
   output ce_pkg::addr_t     req_addr,
   output ce_pkg::credit_t   outstanding
);

   ce_pkg::addr_t   cur_addr;
   ce_pkg::len_t    remaining;
   ce_pkg::credit_t credits;
   logic [4:0]      room_used;   // Reserved FIFO entries

   assign room_used = {1'b0, outstanding} + {1'b0, buf_count};

   // Words left, a credit in hand and a FIFO slot for the completion
   assign req_valid = (remaining != '0) && (credits != '0) &&
                      (room_used < 5'(ce_pkg::CE_CPL_DEPTH));
   assign req_addr  = cur_addr;

   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         cur_addr  <= '0;
         remaining <= '0;
      end else if (start) begin
         cur_addr  <= src_addr;
         remaining <= len;
      end else if (req_valid) begin
         cur_addr  <= cur_addr + ce_pkg::CE_ADDR_STEP;
         remaining <= remaining - ce_pkg::len_t'(1);
      end
   end

   // ----------------------------------------------------------------------
   // Credit and outstanding counters
   // ----------------------------------------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         credits     <= ce_pkg::credit_t'(ce_pkg::CE_REQ_CREDITS);
         outstanding <= '0;
      end else begin
         case ({req_valid, req_credit_return})
            2'b10:   credits <= credits - ce_pkg::credit_t'(1);
            2'b01:   credits <= credits + ce_pkg::credit_t'(1);
            default: ;  // Both or neither
         endcase
         case ({req_valid, cpl_valid})
            2'b10:   outstanding <= outstanding + ce_pkg::credit_t'(1);
            2'b01:   outstanding <= outstanding - ce_pkg::credit_t'(1);
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/ce_cpl_buf.sv
`timescale 1ns/100ps
`default_nettype none

module ce_cpl_buf (
   input  logic              fim_clk,
   input  logic              rst_n,

   input  logic              cpl_valid,   // No back-pressure, room is reserved
   input  ce_pkg::data_t     cpl_data,
   input  logic              pop,

   output logic              head_valid,
   output ce_pkg::data_t     head_data,
   output ce_pkg::credit_t   buf_count
);

   ce_pkg::data_t    mem [ce_pkg::CE_CPL_DEPTH];
   ce_pkg::cpl_ptr_t wr_ptr;
   ce_pkg::cpl_ptr_t rd_ptr;
   logic             do_pop;

   assign head_valid = (buf_count != '0);
   assign head_data  = mem[rd_ptr];
   assign do_pop     = pop && head_valid;

   // Storage
   always_ff @(posedge fim_clk) begin
      if (cpl_valid) begin
         mem[wr_ptr] <= cpl_data;
      end
   end

   // ----------------------------------------------------------------------
   // Pointers and occupancy
   // ----------------------------------------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         buf_count <= '0;
      end else begin
         if (cpl_valid) begin
            wr_ptr <= wr_ptr + ce_pkg::cpl_ptr_t'(1);  // Wraps at depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + ce_pkg::cpl_ptr_t'(1);
         end
         case ({cpl_valid, do_pop})
            2'b10:   buf_count <= buf_count + ce_pkg::credit_t'(1);
            2'b01:   buf_count <= buf_count - ce_pkg::credit_t'(1);
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/ce_wr_master.sv
`timescale 1ns/100ps
`default_nettype none

module ce_wr_master (
   input  logic            fim_clk,
   input  logic            rst_n,

   input  logic            start,
   input  ce_pkg::addr_t   dst_addr,

   input  logic            head_valid,
   input  ce_pkg::data_t   head_data,
   output logic            pop,

   output logic            wr_valid,
   output ce_pkg::addr_t   wr_addr,
   output ce_pkg::data_t   wr_data,
   input  logic            wr_ready,

   output logic            wr_beat
);

   logic accept;

   assign accept  = wr_valid && wr_ready;
   assign wr_beat = accept;

   // Output register is free when empty or being drained this cycle
   assign pop = head_valid && (!wr_valid || wr_ready);

   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_valid <= 1'b0;
      end else if (pop) begin
         wr_valid <= 1'b1;
      end else if (accept) begin
         wr_valid <= 1'b0;
      end
   end

   // Destination steps one word per accepted beat
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_addr <= '0;
      end else if (start) begin
         wr_addr <= dst_addr;
      end else if (accept) begin
         wr_addr <= wr_addr + ce_pkg::CE_ADDR_STEP;
      end
   end

   always_ff @(posedge fim_clk) begin
      if (pop) begin
         wr_data <= head_data;  // Held until accepted
      end
   end

endmodule

`default_nettype wire

// File: hdl/ce_top.sv
`timescale 1ns/100ps
`default_nettype none

module ce_top (
   input  logic                 fim_clk,
   input  logic                 rst_n,

   // MMIO
   input  logic                 mmio_wr_valid,
   input  logic                 mmio_rd_valid,
   input  ce_pkg::mmio_addr_t   mmio_addr,
   input  ce_pkg::data_t        mmio_wdata,
   output logic                 mmio_rd_ack,
   output ce_pkg::data_t        mmio_rdata,

   // Host requests and completions
   output logic                 req_valid,
   output ce_pkg::addr_t        req_addr,
   input  logic                 req_credit_return,
   input  logic                 cpl_valid,
   input  ce_pkg::data_t        cpl_data,

   // Device memory writes
   output logic                 wr_valid,
   output ce_pkg::addr_t        wr_addr,
   output ce_pkg::data_t        wr_data,
   input  logic                 wr_ready
);

   // ----------------------------------------------------------------------
   // Internal wires
   // ----------------------------------------------------------------------
   ce_pkg::addr_t   src_addr;
   ce_pkg::addr_t   dst_addr;
   ce_pkg::len_t    len;
   ce_pkg::len_t    count;
   logic            doorbell;
   logic            start;
   logic            busy;
   logic            done;
   logic            err;

   ce_pkg::credit_t buf_count;
   logic            head_valid;
   ce_pkg::data_t   head_data;
   logic            pop;
   logic            wr_beat;

   ce_csr i_ce_csr (
      .fim_clk       (fim_clk),
      .rst_n         (rst_n),
      .mmio_wr_valid (mmio_wr_valid),
      .mmio_rd_valid (mmio_rd_valid),
      .mmio_addr     (mmio_addr),
      .mmio_wdata    (mmio_wdata),
      .mmio_rd_ack   (mmio_rd_ack),
      .mmio_rdata    (mmio_rdata),
      .busy          (busy),
      .done          (done),
      .err           (err),
      .count         (count),
      .src_addr      (src_addr),
      .dst_addr      (dst_addr),
      .len           (len),
      .doorbell      (doorbell)
   );

   ce_ctrl i_ce_ctrl (
      .fim_clk  (fim_clk),
      .rst_n    (rst_n),
      .doorbell (doorbell),
      .len      (len),
      .wr_beat  (wr_beat),
      .start    (start),
      .busy     (busy),
      .done     (done),
      .err      (err),
      .count    (count)
   );

   ce_rd_req_gen i_ce_rd_req_gen (
      .fim_clk           (fim_clk),
      .rst_n             (rst_n),
      .start             (start),
      .src_addr          (src_addr),
      .len               (len),
      .req_credit_return (req_credit_return),
      .cpl_valid         (cpl_valid),
      .buf_count         (buf_count),
      .req_valid         (req_valid),
      .req_addr          (req_addr),
      .outstanding       ()
   );

   ce_cpl_buf i_ce_cpl_buf (
      .fim_clk    (fim_clk),
      .rst_n      (rst_n),
      .cpl_valid  (cpl_valid),
      .cpl_data   (cpl_data),
      .pop        (pop),
      .head_valid (head_valid),
      .head_data  (head_data),
      .buf_count  (buf_count)
   );

   ce_wr_master i_ce_wr_master (
      .fim_clk    (fim_clk),
      .rst_n      (rst_n),
      .start      (start),
      .dst_addr   (dst_addr),
      .head_valid (head_valid),
      .head_data  (head_data),
      .pop        (pop),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_ready   (wr_ready),
      .wr_beat    (wr_beat)
   );

endmodule

`default_nettype wire

// File: testbench/tb_ce_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ce_top;

   // ----------------------------------------------------------------------
   // Stimulus table
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic [31:0] src;
      logic [31:0] dst;
      int          len;         // Words
      int          stall_pct;   // Chance of wr_ready low in percent
      int          max_delay;   // Upper bound of completion latency
   } row_t;

   localparam int          NROWS      = 6;
   localparam int          WAIT_LIMIT = 5000;  // Cycles
   localparam int          POLL_LIMIT = 50;    // STATUS reads
   localparam logic [63:0] HOST_XOR   = 64'hA5C3_0F96_5A3C_F069;

   localparam row_t ROWS [NROWS] = '{
      '{32'h1000_0000, 32'h0000_2000,  8,  0, 1},
      '{32'h1000_0100, 32'h0000_4000, 20, 30, 4},
      '{32'h2000_0040, 32'h0001_0000, 32, 85, 2},  // Heavy stalls
      '{32'h4000_0000, 32'h0001_8000,  0, 20, 3},  // Zero length
      '{32'h3000_0000, 32'h0002_0000, 12, 10, 8},
      '{32'h0FFF_FFC0, 32'h0003_FFF8, 16, 50, 6}
   };

   logic               fim_clk;
   logic               rst_n;
   logic               mmio_wr_valid;
   logic               mmio_rd_valid;
   ce_pkg::mmio_addr_t mmio_addr;
   ce_pkg::data_t      mmio_wdata;
   logic               mmio_rd_ack;
   ce_pkg::data_t      mmio_rdata;
   logic               req_valid;
   ce_pkg::addr_t      req_addr;
   logic               req_credit_return;
   logic               cpl_valid;
   ce_pkg::data_t      cpl_data;
   logic               wr_valid;
   ce_pkg::addr_t      wr_addr;
   ce_pkg::data_t      wr_data;
   logic               wr_ready;

   // Model state armed per row by the sequencer
   int            cycle;
   int            cur_len;
   int            stall_pct;
   int            max_delay;
   ce_pkg::addr_t exp_src;
   ce_pkg::addr_t exp_dst;
   int            wr_idx;
   int            row_reqs;
   int            row_valid_cycles;
   int            tb_credits;
   int            tb_outstanding;
   logic          hold_pending;
   ce_pkg::addr_t hold_addr;
   ce_pkg::data_t hold_data;

   ce_pkg::addr_t req_q [$];         // Requests waiting for a completion
   int            req_due_q [$];
   int            credit_due_q [$];

   ce_top i_ce_top (
      .fim_clk           (fim_clk),
      .rst_n             (rst_n),
      .mmio_wr_valid     (mmio_wr_valid),
      .mmio_rd_valid     (mmio_rd_valid),
      .mmio_addr         (mmio_addr),
      .mmio_wdata        (mmio_wdata),
      .mmio_rd_ack       (mmio_rd_ack),
      .mmio_rdata        (mmio_rdata),
      .req_valid         (req_valid),
      .req_addr          (req_addr),
      .req_credit_return (req_credit_return),
      .cpl_valid         (cpl_valid),
      .cpl_data          (cpl_data),
      .wr_valid          (wr_valid),
      .wr_addr           (wr_addr),
      .wr_data           (wr_data),
      .wr_ready          (wr_ready)
   );

   initial begin
      fim_clk = 1'b0;
      forever #50 fim_clk = ~fim_clk;
   end

   // Host memory content
   function automatic ce_pkg::data_t host_word(input ce_pkg::addr_t addr);
      return {32'h0, addr} ^ HOST_XOR;
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   // ----------------------------------------------------------------------
   // MMIO access
   // ----------------------------------------------------------------------
   task automatic mmio_write(input ce_pkg::mmio_addr_t addr, input ce_pkg::data_t data);
      @(posedge fim_clk);
      #1;
      mmio_wr_valid = 1'b1;
      mmio_addr     = addr;
      mmio_wdata    = data;
      @(posedge fim_clk);
      #1;
      mmio_wr_valid = 1'b0;
   endtask

   task automatic mmio_read(input ce_pkg::mmio_addr_t addr, output ce_pkg::data_t data);
      @(posedge fim_clk);
      #1;
      assert (mmio_rd_ack == 1'b0) else fail_now("mmio_rd_ack high with no read pending");
      mmio_rd_valid = 1'b1;
      mmio_addr     = addr;
      @(posedge fim_clk);
      #1;
      mmio_rd_valid = 1'b0;
      assert (mmio_rd_ack == 1'b1) else fail_now("mmio_rd_ack missing one cycle after a read");
      data = mmio_rdata;
      @(posedge fim_clk);
      #1;
      assert (mmio_rd_ack == 1'b0) else fail_now("mmio_rd_ack held for more than one cycle");
   endtask

   task automatic check_read(input ce_pkg::mmio_addr_t addr, input ce_pkg::data_t exp,
                             input string name);
      ce_pkg::data_t got;
      mmio_read(addr, got);
      assert (got == exp)
         else fail_now($sformatf("ERROR %s: got %h expected %h", name, got, exp));
   endtask

   // ----------------------------------------------------------------------
   // Bus models and monitors
   // ----------------------------------------------------------------------
   task automatic check_requests();
      ce_pkg::addr_t exp_addr;
      if (req_valid) begin
         exp_addr = exp_src + row_reqs * 8;
         assert (tb_credits > 0) else fail_now("req_valid raised with no request credit left");
         assert (row_reqs < cur_len) else fail_now("More host requests than the copy length");
         assert (req_addr == exp_addr)
            else fail_now($sformatf("ERROR req_addr: got %h expected %h", req_addr, exp_addr));
         req_q.push_back(req_addr);
         req_due_q.push_back(cycle + 1 + int'($urandom % max_delay));
         row_reqs++;
      end
      tb_credits     = tb_credits - (req_valid ? 1 : 0) + (req_credit_return ? 1 : 0);
      tb_outstanding = tb_outstanding + (req_valid ? 1 : 0) - (cpl_valid ? 1 : 0);
      assert (tb_outstanding <= ce_pkg::CE_CPL_DEPTH)
         else fail_now("Outstanding host requests exceed the completion buffer depth");
   endtask

   task automatic check_writes();
      ce_pkg::addr_t exp_addr;
      ce_pkg::data_t exp_data;
      if (hold_pending) begin
         assert (wr_valid) else fail_now("wr_valid dropped before wr_ready was seen");
         assert (wr_addr == hold_addr)
            else fail_now($sformatf("ERROR wr_addr: got %h expected %h", wr_addr, hold_addr));
         assert (wr_data == hold_data)
            else fail_now($sformatf("ERROR wr_data: got %h expected %h", wr_data, hold_data));
      end
      hold_pending = 1'b0;
      if (wr_valid) begin
         row_valid_cycles++;
         if (wr_ready) begin
            exp_addr = exp_dst + wr_idx * 8;
            exp_data = host_word(exp_src + wr_idx * 8);
            assert (wr_idx < cur_len) else fail_now("Device write beyond the copy length");
            assert (wr_addr == exp_addr)
               else fail_now($sformatf("ERROR wr_addr: got %h expected %h", wr_addr, exp_addr));
            assert (wr_data == exp_data)
               else fail_now($sformatf("ERROR wr_data: got %h expected %h", wr_data, exp_data));
            wr_idx++;
         end else begin
            hold_pending = 1'b1;  // Stalled beat must hold next cycle
            hold_addr    = wr_addr;
            hold_data    = wr_data;
         end
      end
   endtask

   // In-order completions and then a credit a few cycles later
   task automatic drive_host();
      cpl_valid         = 1'b0;
      req_credit_return = 1'b0;
      if (req_q.size() > 0 && req_due_q[0] <= cycle) begin
         cpl_valid = 1'b1;
         cpl_data  = host_word(req_q.pop_front());
         void'(req_due_q.pop_front());
         credit_due_q.push_back(cycle + 1 + int'($urandom % 3));
      end
      if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
         req_credit_return = 1'b1;
         void'(credit_due_q.pop_front());
      end
   endtask

   initial begin
      int stall_now;   // Stall rate of the current row
      void'($urandom(74));
      stall_now = 0;
      forever begin
         @(negedge fim_clk);  // Outputs and driven inputs are settled here
         stall_now = stall_pct;
         if (rst_n) begin
            check_requests();
            check_writes();
         end
         @(posedge fim_clk);
         #1;
         cycle++;
         drive_host();
         wr_ready = ($urandom % 100) >= stall_now;
      end
   end

   // ----------------------------------------------------------------------
   // Sequencer
   // ----------------------------------------------------------------------
   task automatic wait_writes(input int n);
      int waited;
      waited = 0;
      while (wr_idx < n) begin
         @(posedge fim_clk);
         waited++;
         assert (waited <= WAIT_LIMIT)
            else fail_now($sformatf("Timed out with %0d of %0d words written", wr_idx, n));
      end
   endtask

   task automatic wait_done(output ce_pkg::data_t status);
      int polls;
      polls  = 0;
      status = '0;
      while (status[1] != 1'b1) begin
         assert (polls < POLL_LIMIT) else fail_now("Timed out polling STATUS for done");
         mmio_read(ce_pkg::CE_REG_STATUS, status);
         polls++;
      end
   endtask

   task automatic run_row(input row_t row);
      ce_pkg::data_t status;
      mmio_write(ce_pkg::CE_REG_SRC, {32'h0, row.src});
      mmio_write(ce_pkg::CE_REG_DST, {32'h0, row.dst});
      mmio_write(ce_pkg::CE_REG_LEN, 64'(row.len));
      check_read(ce_pkg::CE_REG_SRC, {32'h0, row.src}, "SRC");
      check_read(ce_pkg::CE_REG_DST, {32'h0, row.dst}, "DST");
      check_read(ce_pkg::CE_REG_LEN, 64'(row.len), "LEN");

      exp_src          = row.src;
      exp_dst          = row.dst;
      cur_len          = row.len;
      stall_pct        = row.stall_pct;
      max_delay        = row.max_delay;
      wr_idx           = 0;
      row_reqs         = 0;
      row_valid_cycles = 0;

      mmio_write(ce_pkg::CE_REG_CTRL, 64'h1);  // Doorbell
      wait_writes(row.len);
      wait_done(status);

      assert (status[0] == 1'b0)
         else fail_now($sformatf("ERROR busy: got %h expected 0", status[0]));
      assert (status[2] == (row.len == 0))
         else fail_now($sformatf("ERROR err: got %h expected %h", status[2], row.len == 0));
      assert (status[31:16] == 16'(row.len))
         else fail_now($sformatf("ERROR count: got %h expected %h", status[31:16], row.len));
      assert (wr_idx == row.len)
         else fail_now($sformatf("ERROR writes: got %h expected %h", wr_idx, row.len));
      assert (row_reqs == row.len)
         else fail_now($sformatf("ERROR requests: got %h expected %h", row_reqs, row.len));
      if (row.len == 0) begin
         assert (row_valid_cycles == 0) else fail_now("wr_valid seen on a zero-length copy");
      end
   endtask

   initial begin
      rst_n             = 1'b0;
      mmio_wr_valid     = 1'b0;
      mmio_rd_valid     = 1'b0;
      mmio_addr         = '0;
      mmio_wdata        = '0;
      req_credit_return = 1'b0;
      cpl_valid         = 1'b0;
      cpl_data          = '0;
      wr_ready          = 1'b0;
      cycle             = 0;
      cur_len           = 0;
      stall_pct         = 0;
      max_delay         = 1;
      exp_src           = '0;
      exp_dst           = '0;
      wr_idx            = 0;
      row_reqs          = 0;
      row_valid_cycles  = 0;
      tb_credits        = ce_pkg::CE_REQ_CREDITS;
      tb_outstanding    = 0;
      hold_pending      = 1'b0;
      hold_addr         = '0;
      hold_data         = '0;

      repeat (4) @(posedge fim_clk);
      #1;
      rst_n = 1'b1;

      check_read(ce_pkg::CE_REG_ID, {48'h0, ce_pkg::CE_FEAT_ID}, "ID");
      for (int r = 0; r < NROWS; r++) begin
         run_row(ROWS[r]);
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
hdl/ce_pkg.sv
hdl/ce_csr.sv
hdl/ce_ctrl.sv
hdl/ce_rd_req_gen.sv
hdl/ce_cpl_buf.sv
hdl/ce_wr_master.sv
hdl/ce_top.sv
testbench/tb_ce_top.sv

// File: Makefile
# Copy engine simulation with Verilator

SIM        = verilator
TOP        = tb_ce_top
FLIST      = flist.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps
PASS_MSG   = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
